// File: dds_pkg.sv
`default_nettype none

package dds_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    // phase accumulator, f_out = freq_word * f_clk / 2^32
    localparam int phase_width     = 32;
    // output sample, unsigned, midscale 128
    localparam int sample_width    = 8;
    // quarter-wave table index, 64 entries
    localparam int lut_index_width = 6;

    //////////////////////////////////////////////////////////////////////
    // wave select, one-hot
    //////////////////////////////////////////////////////////////////////

    typedef logic [3:0] wave_sel_t;

    localparam wave_sel_t wave_sine     = 4'b0001;
    localparam wave_sel_t wave_square   = 4'b0010;
    localparam wave_sel_t wave_triangle = 4'b0100;
    localparam wave_sel_t wave_saw      = 4'b1000;
    // anything else gives silence

    //////////////////////////////////////////////////////////////////////
    // phase word, two decodes of the same accumulator value
    //////////////////////////////////////////////////////////////////////

    // plain address view for square, saw and triangle
    typedef struct packed {
        logic [sample_width-1:0]             addr;
        logic [phase_width-sample_width-1:0] rest;
    } phase_addr_t;

    // quadrant plus table index for the sine fold
    typedef struct packed {
        logic [1:0]                             quadrant;
        logic [lut_index_width-1:0]             index;
        logic [phase_width-lut_index_width-3:0] rest;
    } phase_fold_t;

    typedef union packed {
        phase_addr_t addr_v;
        phase_fold_t fold_v;
    } phase_word_u;

endpackage

`default_nettype wire

// File: phase_accum.sv
`timescale 1ns/100ps
`default_nettype none

// wrap-around adder register of the DDS
// output frequency is freq_word * f_clk / 2^PHASE_WIDTH
module phase_accum
    import dds_pkg::*;
#(
    parameter int PHASE_WIDTH = phase_width
)
(
    input  logic                   sys_clk,
    input  logic                   rst,
    input  logic [PHASE_WIDTH-1:0] freq_word,
    output phase_word_u            phase
);

    //////////////////////////////////////////////////////////////////////
    // accumulator
    //////////////////////////////////////////////////////////////////////

    // running phase, modulo 2^PHASE_WIDTH
    logic [PHASE_WIDTH-1:0] acc;

    // freq_word taken on the same edge it is sampled
    // so a step change never breaks phase continuity
    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            acc <= '0;
        end
        else
        begin
            // carry out of the top bit simply drops, that is the wrap
            acc <= acc + freq_word;
        end
    end

    // same bits, seen through the union for the downstream decoders
    assign phase = phase_word_u'(acc);

endmodule

`default_nettype wire

// File: sine_lut.sv
`timescale 1ns/100ps
`default_nettype none

// quarter-wave sine table, folded out to a full period
// one cycle from quadrant/index to sine_sample
module sine_lut
    import dds_pkg::*;
(
    input  logic                       sys_clk,
    input  logic                       rst,
    input  logic [1:0]                 quadrant,
    input  logic [lut_index_width-1:0] index,
    output logic [sample_width-1:0]    sine_sample
);

    // midscale pair, upper half starts at 128, lower half mirrors from 127
    localparam logic [sample_width-1:0] mid_up = 8'd128;
    localparam logic [sample_width-1:0] mid_dn = 8'd127;

    logic [lut_index_width-1:0] quarter_addr;
    logic [sample_width-2:0]    quarter_val;

    //////////////////////////////////////////////////////////////////////
    // symmetry fold
    //////////////////////////////////////////////////////////////////////

    // odd quadrants run the table backwards, 63-k is the bitwise inverse
    assign quarter_addr = quadrant[0] ? ~index : index;

    //////////////////////////////////////////////////////////////////////
    // quarter table, q(k) = round(127.5 * sin(2*pi*(k+0.5)/256))
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (quarter_addr)
            // rising edge near zero, steepest part
            6'd0:  quarter_val = 7'd2;
            6'd1:  quarter_val = 7'd5;
            6'd2:  quarter_val = 7'd8;
            6'd3:  quarter_val = 7'd11;
            6'd4:  quarter_val = 7'd14;
            6'd5:  quarter_val = 7'd17;
            6'd6:  quarter_val = 7'd20;
            6'd7:  quarter_val = 7'd23;
            6'd8:  quarter_val = 7'd26;
            6'd9:  quarter_val = 7'd29;
            6'd10: quarter_val = 7'd32;
            6'd11: quarter_val = 7'd36;
            6'd12: quarter_val = 7'd39;
            6'd13: quarter_val = 7'd41;
            6'd14: quarter_val = 7'd44;
            6'd15: quarter_val = 7'd47;
            // second sixteenth
            6'd16: quarter_val = 7'd50;
            6'd17: quarter_val = 7'd53;
            6'd18: quarter_val = 7'd56;
            6'd19: quarter_val = 7'd59;
            6'd20: quarter_val = 7'd61;
            6'd21: quarter_val = 7'd64;
            6'd22: quarter_val = 7'd67;
            6'd23: quarter_val = 7'd70;
            6'd24: quarter_val = 7'd72;
            6'd25: quarter_val = 7'd75;
            6'd26: quarter_val = 7'd77;
            6'd27: quarter_val = 7'd80;
            6'd28: quarter_val = 7'd82;
            6'd29: quarter_val = 7'd84;
            6'd30: quarter_val = 7'd87;
            6'd31: quarter_val = 7'd89;
            // past 45 degrees, slope easing off
            6'd32: quarter_val = 7'd91;
            6'd33: quarter_val = 7'd93;
            6'd34: quarter_val = 7'd96;
            6'd35: quarter_val = 7'd98;
            6'd36: quarter_val = 7'd100;
            6'd37: quarter_val = 7'd101;
            6'd38: quarter_val = 7'd103;
            6'd39: quarter_val = 7'd105;
            6'd40: quarter_val = 7'd107;
            6'd41: quarter_val = 7'd109;
            6'd42: quarter_val = 7'd110;
            6'd43: quarter_val = 7'd112;
            6'd44: quarter_val = 7'd113;
            6'd45: quarter_val = 7'd115;
            6'd46: quarter_val = 7'd116;
            6'd47: quarter_val = 7'd117;
            // flat top, several repeats near the crest
            6'd48: quarter_val = 7'd118;
            6'd49: quarter_val = 7'd120;
            6'd50: quarter_val = 7'd121;
            6'd51: quarter_val = 7'd122;
            6'd52: quarter_val = 7'd122;
            6'd53: quarter_val = 7'd123;
            6'd54: quarter_val = 7'd124;
            6'd55: quarter_val = 7'd125;
            6'd56: quarter_val = 7'd125;
            6'd57: quarter_val = 7'd126;
            6'd58: quarter_val = 7'd126;
            6'd59: quarter_val = 7'd127;
            6'd60: quarter_val = 7'd127;
            6'd61: quarter_val = 7'd127;
            6'd62: quarter_val = 7'd127;
            6'd63: quarter_val = 7'd127;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    // quadrants 0,1 sit above midscale, 2,3 are the mirrored half
    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            sine_sample <= '0;
        end
        else if (quadrant[1])
        begin
            // 127 - q never underflows, q tops out at 127
            sine_sample <= mid_dn - {1'b0, quarter_val};
        end
        else
        begin
            // 128 + q tops out at 255
            sine_sample <= mid_up + {1'b0, quarter_val};
        end
    end

endmodule

`default_nettype wire

// File: wave_shaper.sv
`timescale 1ns/100ps
`default_nettype none

// phase word to output sample, two register stages
// stage 1: sine table plus square, triangle, saw and select delay
// stage 2: one-hot select into data_out
module wave_shaper
    import dds_pkg::*;
(
    input  logic                    sys_clk,
    input  logic                    rst,
    input  phase_word_u             phase,
    input  wave_sel_t               wave_select,
    output logic [sample_width-1:0] data_out
);

    // top bit of the address view picks the half period
    logic                    half;
    // the 8 bits below the top one, triangle ramp before folding
    logic [sample_width-1:0] tri_bits;

    // stage 1 registers
    logic [sample_width-1:0] sine_sample;
    logic [sample_width-1:0] square_q;
    logic [sample_width-1:0] tri_q;
    logic [sample_width-1:0] saw_q;
    wave_sel_t               sel_q;

    //////////////////////////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////////////////////////

    assign half     = phase.addr_v.addr[sample_width-1];
    // 9 top bits in all, spills one bit into the remainder field
    assign tri_bits = {phase.addr_v.addr[sample_width-2:0],
                       phase.addr_v.rest[phase_width-sample_width-1]};

    //////////////////////////////////////////////////////////////////////
    // stage 1
    //////////////////////////////////////////////////////////////////////

    // sine through the fold view, registered inside the table
    sine_lut sine_lut_i
    (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .quadrant    (phase.fold_v.quadrant),
        .index       (phase.fold_v.index),
        .sine_sample (sine_sample)
    );

    // the other three are plain bit picks, registered to match the table
    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            square_q <= '0;
            tri_q    <= '0;
            saw_q    <= '0;
            sel_q    <= '0;
        end
        else
        begin
            square_q <= {sample_width{half}};
            // ramp up on the first half, inverted ramp down on the second
            tri_q    <= half ? ~tri_bits : tri_bits;
            saw_q    <= phase.addr_v.addr;
            sel_q    <= wave_select;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stage 2
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk)
    begin
        if (rst)
        begin
            data_out <= '0;
        end
        else
        begin
            case (sel_q)
                wave_sine:     data_out <= sine_sample;
                wave_square:   data_out <= square_q;
                wave_triangle: data_out <= tri_q;
                wave_saw:      data_out <= saw_q;
                // zero or several bits set, hold silence
                default:       data_out <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dds.sv
`timescale 1ns/100ps
`default_nettype none

// DDS signal generator, top level
// phase accumulator followed by the wave shaper
// phase register to data_out is two cycles
module dds
    import dds_pkg::*;
#(
    parameter int PHASE_WIDTH = phase_width
)
(
    // system clock
    input  logic                    sys_clk,
    // synchronous, active high
    input  logic                    rst,
    // one-hot wave code, sampled every edge
    input  logic [3:0]              wave_select,
    // phase step, sampled every edge
    input  logic [PHASE_WIDTH-1:0]  freq_word,
    // registered sample, unsigned
    output logic [sample_width-1:0] data_out
);

    //////////////////////////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////////////////////////

    // accumulator output, decoded two ways downstream
    phase_word_u phase;

    //////////////////////////////////////////////////////////////////////
    // accumulator
    //////////////////////////////////////////////////////////////////////

    phase_accum #(
        .PHASE_WIDTH (PHASE_WIDTH)
    ) phase_accum_i
    (
        .sys_clk   (sys_clk),
        .rst       (rst),
        .freq_word (freq_word),
        .phase     (phase)
    );

    //////////////////////////////////////////////////////////////////////
    // waveforms and output select
    //////////////////////////////////////////////////////////////////////

    wave_shaper wave_shaper_i
    (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .phase       (phase),
        .wave_select (wave_select),
        .data_out    (data_out)
    );

endmodule

`default_nettype wire

// File: dds_properties.sv
`timescale 1ns/100ps
`default_nettype none

// port-level rules of the DDS top bound into every dds instance
module dds_properties
    import dds_pkg::*;
(
    input logic       sys_clk,
    input logic       rst,
    input logic [3:0] wave_select,
    input logic [7:0] data_out
);

    // running count of property failures
    int fail_count = 0;

    //////////////////////////////////////////////////////////////////////
    // reset
    //////////////////////////////////////////////////////////////////////

    // any edge in reset clears the output
    reset_silent: assert property (@(posedge sys_clk) rst |=> data_out == 8'h00)
    else
    begin
        fail_count++;
        $error("data_out not cleared by reset");
    end

    //////////////////////////////////////////////////////////////////////
    // select decode
    //////////////////////////////////////////////////////////////////////

    // no bit or several bits set gives silence two edges on
    invalid_select_silent: assert property (@(posedge sys_clk) disable iff (rst)
        !$onehot(wave_select) |-> ##2 data_out == 8'h00)
    else
    begin
        fail_count++;
        $error("invalid select code did not give a zero output");
    end

    // square is rail to rail only
    square_levels: assert property (@(posedge sys_clk) disable iff (rst)
        wave_select == wave_square |-> ##2 (data_out == 8'h00 || data_out == 8'hff))
    else
    begin
        fail_count++;
        $error("square output not at a rail");
    end

endmodule

bind dds dds_properties dds_properties_i
(
    .sys_clk     (sys_clk),
    .rst         (rst),
    .wave_select (wave_select),
    .data_out    (data_out)
);

`default_nettype wire

// File: tb_dds.sv
`timescale 1ns/100ps
`default_nettype none

module tb_dds
    import dds_pkg::*;
();

    localparam int    clk_half     = 20;
    localparam int    reset_cycles = 16;
    localparam real   pi           = 3.141592653589793;
    localparam string case_file    = "dds_cases.txt";

    logic                   sys_clk;
    logic                   rst;
    logic [3:0]             wave_select;
    logic [phase_width-1:0] freq_word;
    logic [7:0]             data_out;

    // case list from the data file
    wave_sel_t              case_sel[$];
    logic [phase_width-1:0] case_fw[$];
    int                     case_cyc[$];
    int                     total_cycles;
    bit                     cases_loaded;

    // reference model state
    logic [phase_width-1:0] m_ph0;
    logic [phase_width-1:0] m_ph1;
    wave_sel_t              m_sel0;

    integer seed;
    int     checks;
    int     errors;
    int     prop_fails;

    dds #(
        .PHASE_WIDTH (phase_width)
    ) dut_i
    (
        .sys_clk     (sys_clk),
        .rst         (rst),
        .wave_select (wave_select),
        .freq_word   (freq_word),
        .data_out    (data_out)
    );

    //////////////////////////////////////////////////////////////////////
    // clock and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        sys_clk = 1'b0;
        forever #(clk_half) sys_clk = ~sys_clk;
    end

    // twice the nominal run length with reset included
    initial
    begin
        longint limit_ns;
        wait (cases_loaded);
        limit_ns = longint'(total_cycles + reset_cycles) * 2 * clk_half * 2;
        #(limit_ns);
        $display("timeout: run still going after %0d ns", limit_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // q(k) = 127.5 * sin(2*pi*(k+0.5)/256) rounded to nearest
    function automatic int quarter_value(input int k);
        real x;
        x = 127.5 * $sin(2.0 * pi * (k + 0.5) / 256.0);
        return $rtoi(x + 0.5);
    endfunction

    // expected sample for one phase value and one select code
    function automatic logic [7:0] wave_value(input logic [31:0] ph, input logic [3:0] sel);
        int         k;
        logic [7:0] t;
        k = ph[29:24];
        t = ph[30:23];
        case (sel)
            wave_sine:
            begin
                case (ph[31:30])
                    2'd0: return 8'(128 + quarter_value(k));
                    2'd1: return 8'(128 + quarter_value(63 - k));
                    2'd2: return 8'(127 - quarter_value(k));
                    default: return 8'(127 - quarter_value(63 - k));
                endcase
            end
            wave_square:   return ph[31] ? 8'hff : 8'h00;
            wave_triangle: return ph[31] ? ~t : t;
            wave_saw:      return ph[31:24];
            default:       return 8'h00;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks and stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic check_sample(input logic [7:0] expected, input string what);
        checks++;
        assert (data_out === expected)
        else
        begin
            errors++;
            $display("[ERROR] %0t: %s, expected %0d, actual %0d",
                     $time, what, expected, data_out);
        end
    endtask

    // called on a falling edge and returns on the next one
    task automatic run_cycle(input logic [31:0] fw, input wave_sel_t sel);
        logic [7:0] expected;
        // output after the coming edge uses the phase two back
        expected = wave_value(m_ph1, m_sel0);
        m_ph1    = m_ph0;
        m_ph0    = m_ph0 + fw;
        m_sel0   = sel;
        freq_word   = fw;
        wave_select = sel;
        @(negedge sys_clk);
        check_sample(expected, $sformatf("data_out, select %b", sel));
    endtask

    task automatic run_case(input wave_sel_t sel, input logic [31:0] fw, input int cycles);
        logic [31:0] cur_fw;
        cur_fw = fw;
        for (int i = 0; i < cycles; i++)
        begin
            // zero word marks a random-word case
            if (fw == '0 && (i % 8) == 0)
            begin
                cur_fw = $random(seed);
            end
            run_cycle(cur_fw, sel);
        end
    endtask

    task automatic load_cases();
        int          fd;
        string       line;
        logic [3:0]  sel;
        logic [31:0] fw;
        int          cyc;
        fd = $fopen(case_file, "r");
        if (fd == 0)
        begin
            $display("could not open the case file %s", case_file);
            errors++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                // skip comments and blank lines
                if (line.len() > 0 && line[0] != "#"
                    && $sscanf(line, "%b %h %d", sel, fw, cyc) == 3)
                begin
                    case_sel.push_back(sel);
                    case_fw.push_back(fw);
                    case_cyc.push_back(cyc);
                    total_cycles += cyc;
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        rst          = 1'b1;
        wave_select  = '0;
        freq_word    = '0;
        seed         = 32'h22b17a70;
        checks       = 0;
        errors       = 0;
        prop_fails   = 0;
        total_cycles = 0;
        cases_loaded = 1'b0;
        m_ph0        = '0;
        m_ph1        = '0;
        m_sel0       = '0;

        load_cases();
        cases_loaded = 1'b1;

        // output must stay silent through reset
        for (int i = 0; i < reset_cycles; i++)
        begin
            @(negedge sys_clk);
            check_sample(8'h00, "data_out during reset");
        end
        rst = 1'b0;

        foreach (case_sel[i])
        begin
            run_case(case_sel[i], case_fw[i], case_cyc[i]);
        end

        // let the last two-edge property attempts complete
        repeat (2) @(negedge sys_clk);
        prop_fails = dut_i.dds_properties_i.fail_count;

        $display("cases: %0d, checks: %0d, errors: %0d, property failures: %0d",
                 case_sel.size(), checks, errors, prop_fails);
        if (errors == 0 && prop_fails == 0)
        begin
            $display("ALL TESTS PASSED");
        end
        else
        begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dds_cases.txt
# columns: wave_select (binary), freq_word (hex), cycles (decimal)
# a freq_word of 0 means random words from $random, a new one every 8 cycles
0001 01000000 260
0001 0379a2c5 100
0010 00800000 120
0010 9e3779b9 50
0100 02000000 200
0100 c0000001 40
1000 00abcdef 100
1000 fffff000 40
0001 00300000 60
0001 05000000 60
0000 01234567 20
0011 01234567 20
1111 0a0b0c0d 10
0110 00400000 10
0010 04000000 6
1000 04000000 6
0100 04000000 6
0001 04000000 6
0001 00000000 60
1000 00000000 40

// File: build.f
dds_pkg.sv
phase_accum.sv
sine_lut.sv
wave_shaper.sv
dds.sv
dds_properties.sv
tb_dds.sv

// File: Bender.yml
package:
  name: dds

sources:
  # design
  - dds_pkg.sv
  - phase_accum.sv
  - sine_lut.sv
  - wave_shaper.sv
  - dds.sv
  # testbench
  - target: test
    files:
      - dds_properties.sv
      - tb_dds.sv
